// File: logic/cfg_boot_pkg.sv
// Shared constants and types for the tile config loader.
// Sized for two tiles with a 16-word microcode image; changing
// num_core also needs tile_width to follow.
// Mode registers are one bit wide: 0 is uncached, 1 is normal.
`default_nettype none

package cfg_boot_pkg;

  localparam int num_core         = 2;
  localparam int tile_width       = 1;
  localparam int ucode_els        = 16;
  localparam int ucode_addr_width = 4;
  localparam int ucode_width      = 32;
  localparam int cfg_data_width   = 32;
  localparam int mask_width       = 8;
  localparam int max_credits      = 4;
  localparam int credit_width     = $clog2(max_credits + 1);
  localparam int sync_cycles      = 16;
  localparam int sync_width       = $clog2(sync_cycles);

  localparam logic [mask_width-1:0] domain_mask = 8'h01; // only domain 0 enabled.
  localparam logic                  mode_normal = 1'b1;
  localparam string                 ucode_file  = "cce_ucode.mem";

  typedef enum logic [2:0] {
    reg_reset,
    reg_freeze,
    reg_icache_mode,
    reg_dcache_mode,
    reg_cce_mode,
    reg_domain_mask,
    reg_ucode
  } cfg_reg_e;

  typedef enum logic [3:0] {
    st_reset,
    st_reset_set,
    st_freeze_set,
    st_reset_clr,
    st_send_ucode,
    st_icache_normal,
    st_dcache_normal,
    st_cce_normal,
    st_wait_sync,
    st_domain,
    st_freeze_clr,
    st_wait_credits,
    st_done
  } loader_state_e;

endpackage

`default_nettype wire

// File: logic/cfg_bus_if.sv
// Config write bus: one command strobe with valid/yumi and a
// single-cycle response pulse per accepted write.
// Tiles never back-pressure, so the tile modport has no yumi.
`timescale 1ns/10ps
`default_nettype none

interface cfg_bus_if import cfg_boot_pkg::*; ();

  logic                       cmd_v;
  logic                       cmd_yumi;
  logic [tile_width-1:0]      cmd_tile;
  cfg_reg_e                   cmd_reg;
  logic [ucode_addr_width-1:0] cmd_addr;
  logic [cfg_data_width-1:0]  cmd_data;
  logic                       resp_v;

  modport loader (output cmd_v, cmd_tile, cmd_reg, cmd_addr, cmd_data,
                  input  cmd_yumi, resp_v);

  modport net    (input  cmd_v, cmd_tile, cmd_reg, cmd_addr, cmd_data,
                  output cmd_yumi, resp_v);

  modport tile   (input  cmd_v, cmd_reg, cmd_addr, cmd_data,
                  output resp_v);

endinterface

`default_nettype wire

// File: logic/cfg_loader.sv
// Boot sequence for the tile array: reset, freeze, microcode copy,
// mode switch, sync wait, domain enable and freeze release.
// The ROM image is read from ucode_file at elaboration.
// At most max_credits writes are outstanding; done_o waits for all
// responses and then holds until the next reset.
`timescale 1ns/10ps
`default_nettype none

module cfg_loader import cfg_boot_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  cfg_bus_if.loader bus_o,
  output logic      done_o
);

  logic [ucode_width-1:0] boot_rom [ucode_els];

  initial $readmemb(ucode_file, boot_rom);

  loader_state_e state_r, state_n;

  logic [credit_width-1:0]     credit_r;
  logic [tile_width-1:0]       tile_r;
  logic [ucode_addr_width-1:0] word_r;
  logic [sync_width-1:0]       sync_r;

  logic                      cmd_want;
  logic                      cmd_fire;
  cfg_reg_e                  cmd_reg;
  logic [ucode_addr_width-1:0] cmd_addr;
  logic [cfg_data_width-1:0] cmd_data;

  logic last_tile;
  logic last_word;
  logic sync_done;
  logic credits_full;
  logic credits_empty;

  assign last_tile     = (tile_r == tile_width'(num_core - 1));
  assign last_word     = (word_r == ucode_addr_width'(ucode_els - 1));
  assign sync_done     = (sync_r == sync_width'(sync_cycles - 1));
  assign credits_full  = (credit_r == credit_width'(max_credits));
  assign credits_empty = (credit_r == '0);

  assign bus_o.cmd_v    = cmd_want & ~credits_full;
  assign bus_o.cmd_tile = tile_r;
  assign bus_o.cmd_reg  = cmd_reg;
  assign bus_o.cmd_addr = cmd_addr;
  assign bus_o.cmd_data = cmd_data;

  assign cmd_fire = bus_o.cmd_v & bus_o.cmd_yumi;
  assign done_o   = (state_r == st_done);

  always_comb begin
    state_n  = state_r;
    cmd_want = 1'b0;
    cmd_reg  = reg_reset;
    cmd_addr = '0;
    cmd_data = '0;
    case (state_r)
      st_reset: state_n = st_reset_set;
      st_reset_set: begin
        cmd_want = 1'b1;
        cmd_data = cfg_data_width'(1);
        if (cmd_fire && last_tile) state_n = st_freeze_set;
      end
      st_freeze_set: begin
        cmd_want = 1'b1;
        cmd_reg  = reg_freeze;
        cmd_data = cfg_data_width'(1);
        if (cmd_fire && last_tile) state_n = st_reset_clr;
      end
      st_reset_clr: begin
        cmd_want = 1'b1; // core leaves reset while still frozen.
        if (cmd_fire && last_tile) state_n = st_send_ucode;
      end
      st_send_ucode: begin
        cmd_want = 1'b1;
        cmd_reg  = reg_ucode;
        cmd_addr = word_r;
        cmd_data = boot_rom[word_r];
        if (cmd_fire && last_tile && last_word) state_n = st_icache_normal;
      end
      st_icache_normal: begin
        cmd_want = 1'b1;
        cmd_reg  = reg_icache_mode;
        cmd_data = cfg_data_width'(mode_normal);
        if (cmd_fire && last_tile) state_n = st_dcache_normal;
      end
      st_dcache_normal: begin
        cmd_want = 1'b1;
        cmd_reg  = reg_dcache_mode;
        cmd_data = cfg_data_width'(mode_normal);
        if (cmd_fire && last_tile) state_n = st_cce_normal;
      end
      st_cce_normal: begin
        cmd_want = credits_empty; // earlier mode writes must land first.
        cmd_reg  = reg_cce_mode;
        cmd_data = cfg_data_width'(mode_normal);
        if (cmd_fire && last_tile) state_n = st_wait_sync;
      end
      st_wait_sync: begin
        if (sync_done) state_n = st_domain;
      end
      st_domain: begin
        cmd_want = credits_empty;
        cmd_reg  = reg_domain_mask;
        cmd_data = cfg_data_width'(domain_mask);
        if (cmd_fire && last_tile) state_n = st_freeze_clr;
      end
      st_freeze_clr: begin
        cmd_want = 1'b1;
        cmd_reg  = reg_freeze;
        if (cmd_fire && last_tile) state_n = st_wait_credits;
      end
      st_wait_credits: begin
        if (credits_empty) state_n = st_done;
      end
      st_done: state_n = st_done;
      default: state_n = st_reset;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r  <= st_reset;
      credit_r <= '0;
      tile_r   <= '0;
      word_r   <= '0;
      sync_r   <= '0;
    end else begin
      state_r  <= state_n;
      credit_r <= credit_r + credit_width'(cmd_fire) - credit_width'(bus_o.resp_v);
      if (cmd_fire) begin
        if ((state_r != st_send_ucode) || last_word) begin
          tile_r <= last_tile ? '0 : tile_r + 1'b1;
        end
        if (state_r == st_send_ucode) begin
          word_r <= last_word ? '0 : word_r + 1'b1; // all words per tile, then next tile.
        end
      end
      if (state_r == st_wait_sync) begin
        sync_r <= sync_done ? '0 : sync_r + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/cfg_net.sv
// One-stage config router. Accepts a command whenever stall_i is low,
// holds it one cycle and presents it only to the addressed tile.
// Only one tile is written per cycle, so responses are merged by OR.
`timescale 1ns/10ps
`default_nettype none

module cfg_net import cfg_boot_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      stall_i,
  cfg_bus_if.net    up_i,
  cfg_bus_if.loader tile_o [num_core]
);

  logic                        stage_v_r;
  logic [tile_width-1:0]       stage_tile_r;
  cfg_reg_e                    stage_reg_r;
  logic [ucode_addr_width-1:0] stage_addr_r;
  logic [cfg_data_width-1:0]   stage_data_r;
  logic [num_core-1:0]         tile_resp_v;

  assign up_i.cmd_yumi = up_i.cmd_v & ~stall_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      stage_v_r <= 1'b0;
    end else begin
      stage_v_r <= up_i.cmd_yumi; // one cycle per accepted command.
    end
  end

  always_ff @(posedge clk_i) begin
    if (up_i.cmd_yumi) begin
      stage_tile_r <= up_i.cmd_tile;
      stage_reg_r  <= up_i.cmd_reg;
      stage_addr_r <= up_i.cmd_addr;
      stage_data_r <= up_i.cmd_data;
    end
  end

  for (genvar g = 0; g < num_core; g++) begin : g_tile
    assign tile_o[g].cmd_v    = stage_v_r & (stage_tile_r == tile_width'(g));
    assign tile_o[g].cmd_tile = stage_tile_r;
    assign tile_o[g].cmd_reg  = stage_reg_r;
    assign tile_o[g].cmd_addr = stage_addr_r;
    assign tile_o[g].cmd_data = stage_data_r;
    assign tile_resp_v[g]     = tile_o[g].resp_v;
  end

  assign up_i.resp_v = |tile_resp_v;

endmodule

`default_nettype wire

// File: logic/cfg_tile_regs.sv
// Per-tile config registers and microcode RAM.
// Always accepts; each write gives one response pulse a cycle later.
// Out of reset the core is held in reset and frozen, caches and
// coherence engine uncached, no domains enabled.
// The debug read of the RAM is combinational.
`timescale 1ns/10ps
`default_nettype none

module cfg_tile_regs import cfg_boot_pkg::*; (
  input  logic                        clk_i,
  input  logic                        reset_i,
  cfg_bus_if.tile                     bus_i,
  output logic                        core_reset_o,
  output logic                        core_freeze_o,
  output logic                        icache_mode_o,
  output logic                        dcache_mode_o,
  output logic                        cce_mode_o,
  output logic [mask_width-1:0]       domain_mask_o,
  input  logic [ucode_addr_width-1:0] dbg_addr_i,
  output logic [ucode_width-1:0]      dbg_ucode_o
);

  logic [ucode_width-1:0] ucode_mem [ucode_els];
  logic                   resp_v_r;

  assign bus_i.resp_v = resp_v_r;
  assign dbg_ucode_o  = ucode_mem[dbg_addr_i];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      core_reset_o  <= 1'b1;
      core_freeze_o <= 1'b1;
      icache_mode_o <= 1'b0;
      dcache_mode_o <= 1'b0;
      cce_mode_o    <= 1'b0;
      domain_mask_o <= '0;
      resp_v_r      <= 1'b0;
    end else begin
      resp_v_r <= bus_i.cmd_v;
      if (bus_i.cmd_v) begin
        case (bus_i.cmd_reg)
          reg_reset:       core_reset_o  <= bus_i.cmd_data[0];
          reg_freeze:      core_freeze_o <= bus_i.cmd_data[0];
          reg_icache_mode: icache_mode_o <= bus_i.cmd_data[0];
          reg_dcache_mode: dcache_mode_o <= bus_i.cmd_data[0];
          reg_cce_mode:    cce_mode_o    <= bus_i.cmd_data[0];
          reg_domain_mask: domain_mask_o <= bus_i.cmd_data[mask_width-1:0];
          default: ; // ucode writes go to the RAM.
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_i.cmd_v && (bus_i.cmd_reg == reg_ucode)) begin
      ucode_mem[bus_i.cmd_addr] <= bus_i.cmd_data;
    end
  end

endmodule

`default_nettype wire

// File: logic/cfg_boot_top.sv
// Tile array boot block: loader, config router and one register
// block per tile. Tile outputs are packed one element per tile.
// dbg_tile_i and dbg_addr_i select a microcode word to read back.
`timescale 1ns/10ps
`default_nettype none

module cfg_boot_top import cfg_boot_pkg::*; (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                stall_i,
  output logic                                done_o,
  output logic [num_core-1:0]                 core_reset_o,
  output logic [num_core-1:0]                 core_freeze_o,
  output logic [num_core-1:0]                 icache_mode_o,
  output logic [num_core-1:0]                 dcache_mode_o,
  output logic [num_core-1:0]                 cce_mode_o,
  output logic [num_core-1:0][mask_width-1:0] domain_mask_o,
  input  logic [tile_width-1:0]               dbg_tile_i,
  input  logic [ucode_addr_width-1:0]         dbg_addr_i,
  output logic [ucode_width-1:0]              dbg_ucode_o
);

  cfg_bus_if up_bus ();
  cfg_bus_if tile_bus [num_core] ();

  logic [ucode_width-1:0] dbg_ucode [num_core];

  cfg_loader i_loader (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .bus_o   (up_bus.loader),
    .done_o  (done_o)
  );

  cfg_net i_net (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .stall_i (stall_i),
    .up_i    (up_bus.net),
    .tile_o  (tile_bus)
  );

  for (genvar g = 0; g < num_core; g++) begin : g_tile
    cfg_tile_regs i_tile_regs (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .bus_i         (tile_bus[g].tile),
      .core_reset_o  (core_reset_o[g]),
      .core_freeze_o (core_freeze_o[g]),
      .icache_mode_o (icache_mode_o[g]),
      .dcache_mode_o (dcache_mode_o[g]),
      .cce_mode_o    (cce_mode_o[g]),
      .domain_mask_o (domain_mask_o[g]),
      .dbg_addr_i    (dbg_addr_i),
      .dbg_ucode_o   (dbg_ucode[g])
    );
  end

  assign dbg_ucode_o = dbg_ucode[dbg_tile_i];

endmodule

`default_nettype wire

// File: test/tb_cfg_boot.sv
// Testbench for the tile config boot block.
// Stall rates and the expected microcode image and domain mask come
// from test/boot_input.txt, so it must run from the project root.
// Each run resets the DUT and waits for done_o under a cycle limit.
`timescale 1ns/10ps
`default_nettype none

module tb_cfg_boot import cfg_boot_pkg::*; ();

  localparam int num_runs    = 3;
  localparam int vec_len     = num_runs + ucode_els + 1;
  localparam int mask_index  = num_runs + ucode_els;
  localparam int base_cycles = num_core * (ucode_els + 8) + sync_cycles + 24; // unstalled, rounded up.
  localparam int run_limit   = 20 * base_cycles + 100;
  localparam int hold_cycles = 20;
  localparam int state_width = num_core * (5 + mask_width);

  logic                                clk   = 1'b0;
  logic                                stall = 1'b0;
  logic                                reset;
  logic                                done;
  logic [num_core-1:0]                 core_reset;
  logic [num_core-1:0]                 core_freeze;
  logic [num_core-1:0]                 icache_mode;
  logic [num_core-1:0]                 dcache_mode;
  logic [num_core-1:0]                 cce_mode;
  logic [num_core-1:0][mask_width-1:0] domain_mask;
  logic [tile_width-1:0]               dbg_tile;
  logic [ucode_addr_width-1:0]         dbg_addr;
  logic [ucode_width-1:0]              dbg_ucode;

  logic [31:0]            vec [vec_len];
  int                     stall_pct = 0;
  int                     errors    = 0;
  int                     checks    = 0;
  logic [num_core-1:0]    prev_core_reset;
  logic                   done_seen;
  logic [state_width-1:0] done_state;

  cfg_boot_top i_cfg_boot_top (
    .clk_i         (clk),
    .reset_i       (reset),
    .stall_i       (stall),
    .done_o        (done),
    .core_reset_o  (core_reset),
    .core_freeze_o (core_freeze),
    .icache_mode_o (icache_mode),
    .dcache_mode_o (dcache_mode),
    .cce_mode_o    (cce_mode),
    .domain_mask_o (domain_mask),
    .dbg_tile_i    (dbg_tile),
    .dbg_addr_i    (dbg_addr),
    .dbg_ucode_o   (dbg_ucode)
  );

  always #2 clk = ~clk;

  always @(negedge clk) begin
    stall <= (($urandom % 100) < stall_pct); // fresh draw every cycle.
  end

  function automatic logic [state_width-1:0] tile_state();
    return {core_reset, core_freeze, icache_mode, dcache_mode, cce_mode, domain_mask};
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED at time %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  // reset release order and output stability once done.
  always @(negedge clk) begin
    if (reset) begin
      prev_core_reset <= '1;
      done_seen       <= 1'b0;
    end else begin
      for (int t = 0; t < num_core; t++) begin
        if (prev_core_reset[t] && !core_reset[t]) begin
          compare_value($sformatf("core_freeze_o[%0d]", t), 32'(core_freeze[t]), 32'd1);
          compare_value($sformatf("icache_mode_o[%0d]", t), 32'(icache_mode[t]), 32'd0);
          compare_value($sformatf("dcache_mode_o[%0d]", t), 32'(dcache_mode[t]), 32'd0);
          compare_value($sformatf("cce_mode_o[%0d]", t), 32'(cce_mode[t]), 32'd0);
          compare_value($sformatf("domain_mask_o[%0d]", t), 32'(domain_mask[t]), 32'd0);
        end
      end
      prev_core_reset <= core_reset;
      if (done_seen) begin
        compare_value("done_o", 32'(done), 32'd1);
        compare_value("tile outputs", 32'(tile_state()), 32'(done_state));
      end else if (done) begin
        done_seen  <= 1'b1;
        done_state <= tile_state();
      end
    end
  end

  task automatic apply_reset(input int pct);
    @(negedge clk);
    reset     <= 1'b1;
    stall_pct <= pct;
    repeat (3) @(negedge clk);
    reset <= 1'b0;
  endtask

  task automatic verify_reset_values();
    @(negedge clk);
    compare_value("done_o", 32'(done), 32'd0);
    compare_value("core_reset_o", 32'(core_reset), 32'({num_core{1'b1}}));
    compare_value("core_freeze_o", 32'(core_freeze), 32'({num_core{1'b1}}));
    compare_value("icache_mode_o", 32'(icache_mode), 32'd0);
    compare_value("dcache_mode_o", 32'(dcache_mode), 32'd0);
    compare_value("cce_mode_o", 32'(cce_mode), 32'd0);
    compare_value("domain_mask_o", 32'(domain_mask), 32'd0);
  endtask

  task automatic verify_boot_result();
    compare_value("core_reset_o", 32'(core_reset), 32'd0);
    compare_value("core_freeze_o", 32'(core_freeze), 32'd0);
    compare_value("icache_mode_o", 32'(icache_mode), 32'({num_core{mode_normal}}));
    compare_value("dcache_mode_o", 32'(dcache_mode), 32'({num_core{mode_normal}}));
    compare_value("cce_mode_o", 32'(cce_mode), 32'({num_core{mode_normal}}));
    for (int t = 0; t < num_core; t++) begin
      compare_value($sformatf("domain_mask_o[%0d]", t), 32'(domain_mask[t]),
                    32'(vec[mask_index][mask_width-1:0]));
    end
  endtask

  task automatic read_back_ucode();
    for (int t = 0; t < num_core; t++) begin
      for (int a = 0; a < ucode_els; a++) begin
        @(negedge clk);
        dbg_tile <= tile_width'(t);
        dbg_addr <= ucode_addr_width'(a);
        #1;
        compare_value($sformatf("dbg_ucode_o tile %0d word %0d", t, a), dbg_ucode,
                      vec[num_runs + a]);
      end
    end
  endtask

  initial begin : main
    logic timed_out;
    int   cycles;
    timed_out = 1'b0;
    reset     = 1'b1;
    dbg_tile  = '0;
    dbg_addr  = '0;
    void'($urandom(50));
    $readmemh("test/boot_input.txt", vec);
    for (int r = 0; r < num_runs; r++) begin
      if (!timed_out) begin
        apply_reset(int'(vec[r]));
        verify_reset_values();
        cycles = 0;
        while (!done && cycles < run_limit) begin
          @(negedge clk);
          cycles++;
        end
        if (!done) begin
          timed_out = 1'b1;
          errors++;
          $display("timeout in run %0d: done_o did not rise within %0d cycles", r, run_limit);
        end else begin
          verify_boot_result();
          read_back_ucode();
          repeat (hold_cycles) @(negedge clk); // outputs must hold while done.
        end
      end
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
logic/cfg_boot_pkg.sv
logic/cfg_bus_if.sv
logic/cfg_loader.sv
logic/cfg_net.sv
logic/cfg_tile_regs.sv
logic/cfg_boot_top.sv
test/tb_cfg_boot.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cfg_boot
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  := RESULT: PASS
ROM_IMAGE := cce_ucode.mem
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the loader reads its ROM image from the run directory
$(ROM_IMAGE): logic/$(ROM_IMAGE)
	cp logic/$(ROM_IMAGE) $@

run: $(BUILD_DIR)/V$(TOP) $(ROM_IMAGE)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG) $(ROM_IMAGE)

// File: logic/cce_ucode.mem
10000000000000000000000011110000
10000001000000000000000011100001
10000010000000000000000011010010
10000011000000000000000011000011
10000100000000000000000010110100
10000101000000000000000010100101
10000110000000000000000010010110
10000111000000000000000010000111
10001000000000000000000001111000
10001001000000000000000001101001
10001010000000000000000001011010
10001011000000000000000001001011
10001100000000000000000000111100
10001101000000000000000000101101
10001110000000000000000000011110
10001111000000000000000000001111

// File: test/boot_input.txt
// one hex value per line: entries 0-2 are the stall percent of each run,
// entries 3-18 the expected microcode words 0-15, entry 19 the expected domain mask
// stall percent per run: 0, 50, 90
00
32
5A
// expected microcode image
800000F0
810000E1
820000D2
830000C3
840000B4
850000A5
86000096
87000087
88000078
89000069
8A00005A
8B00004B
8C00003C
8D00002D
8E00001E
8F00000F
// expected domain mask
01
